// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

FAIL_MSG := Simulation FAILED
PASS_MSG := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cache/cache_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

// small register file, one entry per set
module cache_array #(
    parameter type payload_t = logic,
    parameter int  depth     = `CACHE_SETS
) (
    input  wire logic                            clk,
    input  wire logic                            write,
    input  wire lc3b_types_pkg::lc3b_cache_index index,
    input  wire payload_t                        wdata,
    output payload_t                             rdata
);

    payload_t entries [depth];

    // write on the edge
    always_ff @(posedge clk) begin
        if (write) begin
            entries[index] <= wdata;
        end
    end

    // read is combinational so hit logic settles in the same cycle
    assign rdata = entries[index];

endmodule : cache_array

`default_nettype wire

// ==== cache/cache_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_control (
    input  wire logic                clk,
    input  wire logic                rst_n,
    // cpu request
    input  wire logic                mem_read,
    input  wire logic                mem_write,
    // datapath status
    input  wire logic                hit_0,
    input  wire logic                hit_1,
    input  wire logic                dirty,
    input  wire logic                lru,
    input  wire logic                pmem_resp,
    // datapath steering
    output cache_ctrl_pkg::way_sel_t way_sel,
    output logic                     data_source_sel,
    output logic                     tag_bypass_sel,
    output logic                     load,
    output logic                     load_lru,
    // handshakes
    output logic                     mem_resp,
    output logic                     pmem_read,
    output logic                     pmem_write
);
    import cache_ctrl_pkg::*;

    cache_state_t state;
    cache_state_t next_state;
    logic         request;
    logic         hit;

    assign request = mem_read | mem_write;
    assign hit     = hit_0 | hit_1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle_compare;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // defaults target the lru way with the request tag
        next_state      = state;
        way_sel         = way_sel_t'(lru);
        data_source_sel = 1'b0;
        tag_bypass_sel  = 1'b1;
        load            = 1'b0;
        load_lru        = 1'b0;
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;

        unique case (state)
            idle_compare: begin
                if (hit) begin
                    way_sel = hit_1 ? way1 : way0;
                end
                if (request) begin
                    if (hit) begin
                        // answered this cycle, write merges under the cpu mask
                        mem_resp = 1'b1;
                        load_lru = 1'b1;
                        load     = mem_write;
                    end else if (dirty) begin
                        next_state = write_back;
                    end else begin
                        next_state = allocate;
                    end
                end
            end

            write_back: begin
                // victim tag and line go out
                tag_bypass_sel = 1'b0;
                pmem_write     = 1'b1;
                if (pmem_resp) begin
                    next_state = allocate;
                end
            end

            allocate: begin
                data_source_sel = 1'b1;
                pmem_read       = 1'b1;
                if (pmem_resp) begin
                    load       = 1'b1;
                    next_state = idle_compare;
                end
            end

            default: begin
                next_state = idle_compare;
            end
        endcase
    end

endmodule : cache_control

`default_nettype wire

// ==== cache/cache_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_datapath (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    // steering from the controller
    input  wire cache_ctrl_pkg::way_sel_t       way_sel,
    input  wire logic                           data_source_sel,
    input  wire logic                           tag_bypass_sel,
    input  wire logic                           load,
    input  wire logic                           load_lru,
    // cpu side
    input  wire lc3b_types_pkg::lc3b_word       cpu_address,
    input  wire lc3b_types_pkg::lc3b_byte_mask  cpu_byte_sel,
    input  wire lc3b_types_pkg::lc3b_cache_word cpu_data_in,
    // memory side
    input  wire lc3b_types_pkg::lc3b_cache_word memory_data_in,
    // status back to the controller
    output logic                                hit_0,
    output logic                                hit_1,
    output logic                                dirty,
    output logic                                lru,
    output lc3b_types_pkg::lc3b_cache_word      cpu_data_out,
    output lc3b_types_pkg::lc3b_word            memory_address,
    output lc3b_types_pkg::lc3b_cache_word      memory_data_out
);
    import lc3b_types_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int tag_lsb = `CACHE_OFFSET_W + `CACHE_INDEX_W;

    lc3b_cache_tag   tag_in;
    lc3b_cache_index index;
    lc3b_cache_word  data_in;
    lc3b_byte_mask   byte_sel;

    lc3b_cache_tag   tag_0;
    lc3b_cache_tag   tag_1;
    lc3b_cache_tag   tag_out;
    lc3b_cache_word  data_0;
    lc3b_cache_word  data_1;
    lc3b_cache_word  data_out;
    logic            dirty_0;
    logic            dirty_1;
    logic            load_0;
    logic            load_1;

    logic [`CACHE_SETS-1:0] lru_bits;

    // address split
    assign tag_in = cpu_address[tag_lsb +: `CACHE_TAG_W];
    assign index  = cpu_address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    // fills take the whole line
    assign data_in  = data_source_sel ? memory_data_in : cpu_data_in;
    assign byte_sel = data_source_sel ? '1 : cpu_byte_sel;

    // only the selected way sees the load
    assign load_0 = load && (way_sel == way0);
    assign load_1 = load && (way_sel == way1);

    cache_way cache_way_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_0),
        .load_type (data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (tag_in),
        .index     (index),
        .data_in   (data_in),
        .tag_out   (tag_0),
        .data_out  (data_0),
        .dirty     (dirty_0),
        .hit       (hit_0)
    );

    cache_way cache_way_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_1),
        .load_type (data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (tag_in),
        .index     (index),
        .data_in   (data_in),
        .tag_out   (tag_1),
        .data_out  (data_1),
        .dirty     (dirty_1),
        .hit       (hit_1)
    );

    assign data_out        = (way_sel == way1) ? data_1 : data_0;
    assign tag_out         = (way_sel == way1) ? tag_1 : tag_0;
    assign cpu_data_out    = data_out;
    assign memory_data_out = data_out;

    // victim tag for write-back, request tag for the refill
    assign memory_address = {tag_bypass_sel ? tag_in : tag_out, index,
                             {`CACHE_OFFSET_W{1'b0}}};

    // lru bit points at the way to evict next
    assign lru   = lru_bits[index];
    assign dirty = lru ? dirty_1 : dirty_0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (load_lru) begin
            lru_bits[index] <= (way_sel == way0);
        end
    end

endmodule : cache_datapath

`default_nettype wire

// ==== cache/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_way (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            load,
    input  wire logic                            load_type,
    input  wire lc3b_types_pkg::lc3b_byte_mask   byte_sel,
    input  wire lc3b_types_pkg::lc3b_cache_tag   tag_in,
    input  wire lc3b_types_pkg::lc3b_cache_index index,
    input  wire lc3b_types_pkg::lc3b_cache_word  data_in,
    output lc3b_types_pkg::lc3b_cache_tag        tag_out,
    output lc3b_types_pkg::lc3b_cache_word       data_out,
    output logic                                 dirty,
    output logic                                 hit
);
    import lc3b_types_pkg::*;

    localparam int line_bytes = `CACHE_LINE_BITS / 8;

    logic [`CACHE_SETS-1:0] valid_bits;
    logic [`CACHE_SETS-1:0] dirty_bits;
    lc3b_cache_word         merged_line;

    cache_array #(.payload_t(lc3b_cache_tag)) tag_array (
        .clk   (clk),
        .write (load),
        .index (index),
        .wdata (tag_in),
        .rdata (tag_out)
    );

    cache_array #(.payload_t(lc3b_cache_word)) data_array (
        .clk   (clk),
        .write (load),
        .index (index),
        .wdata (merged_line),
        .rdata (data_out)
    );

    // masked bytes come from the input, the rest keep the stored line
    always_comb begin
        for (int i = 0; i < line_bytes; i++) begin
            merged_line[i*8 +: 8] = byte_sel[i] ? data_in[i*8 +: 8] : data_out[i*8 +: 8];
        end
    end

    // cpu write marks dirty, a fill from memory leaves the line clean
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (load) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= ~load_type;
        end
    end

    assign dirty = dirty_bits[index];
    assign hit   = valid_bits[index] && (tag_out == tag_in);

endmodule : cache_way

`default_nettype wire

// ==== common/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// sets per way
`define CACHE_SETS 8

// address split, tag + index + offset = 16
`define CACHE_TAG_W 9
`define CACHE_INDEX_W 3
`define CACHE_OFFSET_W 4

// 16 bytes per line
`define CACHE_LINE_BITS 128

`endif

// ==== common/cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

    // miss handling walks write_back only for a dirty victim
    typedef enum logic [1:0] {
        idle_compare,
        write_back,
        allocate
    } cache_state_t;

    typedef enum logic {
        way0,
        way1
    } way_sel_t;

endpackage : cache_ctrl_pkg

`default_nettype wire

// ==== common/lc3b_types_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package lc3b_types_pkg;

    // 16-bit address or data word
    typedef logic [15:0] lc3b_word;

    // one full cache line
    typedef logic [`CACHE_LINE_BITS-1:0] lc3b_cache_word;

    // address bits 15..7
    typedef logic [`CACHE_TAG_W-1:0] lc3b_cache_tag;

    // address bits 6..4
    typedef logic [`CACHE_INDEX_W-1:0] lc3b_cache_index;

    // one enable per byte of the line
    typedef logic [`CACHE_LINE_BITS/8-1:0] lc3b_byte_mask;

endpackage : lc3b_types_pkg

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    // cpu port
    input  wire logic                           mem_read,
    input  wire logic                           mem_write,
    input  wire lc3b_types_pkg::lc3b_word       mem_address,
    input  wire lc3b_types_pkg::lc3b_byte_mask  mem_byte_enable,
    input  wire lc3b_types_pkg::lc3b_cache_word mem_wdata,
    output lc3b_types_pkg::lc3b_cache_word      mem_rdata,
    output logic                                mem_resp,
    // physical memory port
    output logic                                pmem_read,
    output logic                                pmem_write,
    output lc3b_types_pkg::lc3b_word            pmem_address,
    output lc3b_types_pkg::lc3b_cache_word      pmem_wdata,
    input  wire lc3b_types_pkg::lc3b_cache_word pmem_rdata,
    input  wire logic                           pmem_resp
);
    import cache_ctrl_pkg::*;

    way_sel_t way_sel;
    logic     data_source_sel;
    logic     tag_bypass_sel;
    logic     load;
    logic     load_lru;
    logic     hit_0;
    logic     hit_1;
    logic     dirty;
    logic     lru;

    cache_control control (
        .clk, .rst_n,
        .mem_read, .mem_write,
        .hit_0, .hit_1, .dirty, .lru,
        .pmem_resp,
        .way_sel, .data_source_sel, .tag_bypass_sel, .load, .load_lru,
        .mem_resp, .pmem_read, .pmem_write
    );

    cache_datapath datapath (
        .clk, .rst_n,
        .way_sel, .data_source_sel, .tag_bypass_sel, .load, .load_lru,
        .cpu_address     (mem_address),
        .cpu_byte_sel    (mem_byte_enable),
        .cpu_data_in     (mem_wdata),
        .memory_data_in  (pmem_rdata),
        .hit_0, .hit_1, .dirty, .lru,
        .cpu_data_out    (mem_rdata),
        .memory_address  (pmem_address),
        .memory_data_out (pmem_wdata)
    );

endmodule : cache_top

`default_nettype wire

// ==== project.f ====
+incdir+common
common/lc3b_types_pkg.sv
common/cache_ctrl_pkg.sv
cache/cache_array.sv
cache/cache_way.sv
cache/cache_datapath.sv
cache/cache_control.sv
hw/cache_top.sv
sim/tb_clock.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// ==== sim/cache_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_asserts (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire logic                     mem_read,
    input wire logic                     mem_write,
    input wire logic                     mem_resp,
    input wire logic                     pmem_read,
    input wire logic                     pmem_write,
    input wire logic                     pmem_resp,
    input wire lc3b_types_pkg::lc3b_word pmem_address
);

    // failure tallies, one per property
    int exclusive_fails  = 0;
    int read_hold_fails  = 0;
    int write_hold_fails = 0;
    int resp_fails       = 0;
    int reset_fails      = 0;
    int failures;

    assign failures = exclusive_fails + read_hold_fails + write_hold_fails
                    + resp_fails + reset_fails;

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write)
    ) else begin
        $error("pmem_read and pmem_write high together");
        exclusive_fails++;
    end

    // strobe and address held until the memory answers
    read_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pmem_read && !pmem_resp) |=> (pmem_read && $stable(pmem_address))
    ) else begin
        $error("pmem_read dropped or pmem_address moved before pmem_resp");
        read_hold_fails++;
    end

    write_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pmem_write && !pmem_resp) |=> (pmem_write && $stable(pmem_address))
    ) else begin
        $error("pmem_write dropped or pmem_address moved before pmem_resp");
        write_hold_fails++;
    end

    resp_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n) mem_resp |-> (mem_read || mem_write)
    ) else begin
        $error("mem_resp without a cpu request");
        resp_fails++;
    end

    // in reset and on the first edge after it
    quiet_in_reset: assert property (
        @(posedge clk) (!rst_n || $rose(rst_n)) |-> !(pmem_read || pmem_write || mem_resp)
    ) else begin
        $error("strobe active during or right after reset");
        reset_fails++;
    end

endmodule : cache_asserts

`default_nettype wire

// ==== sim/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_tb;
    import lc3b_types_pkg::*;

    localparam int num_requests = 240;
    localparam int period_ns    = 20;
    localparam int reset_cycles = 8;
    localparam int line_count   = 4096;
    // dirty miss, two memory accesses of up to 4 cycles plus 3
    localparam int worst_miss     = 2 * 4 + 3;
    localparam int timeout_cycles = 2 * num_requests * worst_miss + reset_cycles + 50;

    logic           clk;
    logic           rst_n;
    logic           mem_read;
    logic           mem_write;
    lc3b_word       mem_address;
    lc3b_byte_mask  mem_byte_enable;
    lc3b_cache_word mem_wdata;
    lc3b_cache_word mem_rdata;
    logic           mem_resp;
    logic           pmem_read;
    logic           pmem_write;
    lc3b_word       pmem_address;
    lc3b_cache_word pmem_wdata;
    lc3b_cache_word pmem_rdata;
    logic           pmem_resp;

    lc3b_cache_word mem_lines [line_count];
    lc3b_cache_word shadow    [line_count];

    // expected residency per set and slot
    logic          res_valid [`CACHE_SETS][2];
    lc3b_cache_tag res_tag   [`CACHE_SETS][2];
    logic          res_dirty [`CACHE_SETS][2];
    logic          lru_slot  [`CACHE_SETS];

    // expected memory traffic as {write, address} in a small ring
    logic [16:0] plan_ops [4];
    int          ops_planned  = 0;
    int          ops_seen     = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    tb_clock #(.period_ns(period_ns), .reset_cycles(reset_cycles)) clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cache_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp)
    );

    bind cache_top cache_asserts protocol_checks (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_resp    (pmem_resp),
        .pmem_address (pmem_address)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // every word mixes the line address with its own position
    function automatic lc3b_cache_word fill_line(input logic [11:0] line_addr);
        lc3b_cache_word line;
        logic [3:0]     word_idx;
        for (int w = 0; w < 8; w++) begin
            word_idx = 4'(w);
            line[w*16 +: 16] = ({line_addr, word_idx} * 16'h9e37) ^ {word_idx, line_addr};
        end
        return line;
    endfunction

    function automatic lc3b_cache_word merge_bytes(
        input lc3b_cache_word old_line,
        input lc3b_cache_word new_line,
        input lc3b_byte_mask  mask
    );
        lc3b_cache_word result;
        for (int b = 0; b < 16; b++) begin
            result[b*8 +: 8] = mask[b] ? new_line[b*8 +: 8] : old_line[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic report_mismatch(
        input string      name,
        input logic [127:0] expected,
        input logic [127:0] actual
    );
        value_errors++;
        $display("FAIL %s expected %0h got %0h at %0t", name, expected, actual, $time);
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    task automatic plan_access(input logic is_write, input lc3b_word address);
        plan_ops[2'(ops_planned)] = {is_write, address};
        ops_planned++;
    endtask

    // updates the residency model and queues the traffic a request must cause
    task automatic predict_traffic(
        input lc3b_cache_tag   tag,
        input lc3b_cache_index set_index,
        input logic            is_write
    );
        logic slot;
        slot = lru_slot[set_index];
        if (res_valid[set_index][0] && res_tag[set_index][0] == tag) begin
            slot = 1'b0;
        end else if (res_valid[set_index][1] && res_tag[set_index][1] == tag) begin
            slot = 1'b1;
        end else begin
            // miss replaces the less recently used slot
            if (res_valid[set_index][slot] && res_dirty[set_index][slot]) begin
                plan_access(1'b1, {res_tag[set_index][slot], set_index, 4'h0});
            end
            plan_access(1'b0, {tag, set_index, 4'h0});
            res_valid[set_index][slot] = 1'b1;
            res_tag[set_index][slot]   = tag;
            res_dirty[set_index][slot] = 1'b0;
        end
        if (is_write) begin
            res_dirty[set_index][slot] = 1'b1;
        end
        lru_slot[set_index] = ~slot;
    endtask

    // answers after 1 to 4 cycles with a one-cycle pmem_resp
    initial begin : memory_model
        logic [31:0]    mem_rng;
        logic [11:0]    line;
        logic           is_write;
        lc3b_cache_word wdata;
        int             delay;
        mem_rng    = 32'd89166;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        for (int a = 0; a < line_count; a++) begin
            mem_lines[a] = fill_line(12'(a));
        end
        forever begin
            @(negedge clk);
            if (rst_n && (pmem_read || pmem_write)) begin
                line     = pmem_address[15:4];
                is_write = pmem_write;
                wdata    = pmem_wdata;
                assert (ops_seen < ops_planned)
                    else report_problem("memory access that no request needs");
                if (ops_seen < ops_planned) begin
                    assert (is_write == plan_ops[2'(ops_seen)][16])
                        else report_problem("memory access of the wrong kind");
                    assert (pmem_address == plan_ops[2'(ops_seen)][15:0])
                        else report_mismatch("pmem_address",
                                             128'(plan_ops[2'(ops_seen)][15:0]),
                                             128'(pmem_address));
                    ops_seen++;
                end
                if (is_write) begin
                    assert (wdata == shadow[line])
                        else report_mismatch("pmem_wdata", shadow[line], wdata);
                    mem_lines[line] = wdata;
                end
                mem_rng = lcg_next(mem_rng);
                delay   = int'(mem_rng[17:16]) + 1;
                repeat (delay) @(posedge clk);
                pmem_rdata <= mem_lines[line];
                pmem_resp  <= 1'b1;
                @(posedge clk);
                pmem_resp  <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0]     rng;
        lc3b_cache_tag   tags [4];
        lc3b_cache_index sets [2];
        lc3b_cache_tag   tag;
        lc3b_cache_index set_index;
        logic            is_write;
        lc3b_byte_mask   mask;
        lc3b_cache_word  data;
        logic [11:0]     line;
        int              waited;
        int              planned_before;
        int              protocol_errors;
        tags            = '{9'h012, 9'h0a5, 9'h133, 9'h1c6};
        sets            = '{3'd2, 3'd5};
        rng             = 32'd89166;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        res_valid       = '{default: '0};
        res_tag         = '{default: '0};
        res_dirty       = '{default: '0};
        lru_slot        = '{default: 1'b0};
        for (int a = 0; a < line_count; a++) begin
            shadow[a] = fill_line(12'(a));
        end
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);

        for (int n = 0; n < num_requests; n++) begin
            rng       = lcg_next(rng);
            tag       = tags[rng[17:16]];
            set_index = sets[rng[18]];
            is_write  = rng[19];
            line      = {tag, set_index};
            mem_address <= {tag, set_index, rng[23:20]};
            rng  = lcg_next(rng);
            mask = rng[31:16];
            for (int w = 0; w < 8; w++) begin
                rng = lcg_next(rng);
                data[w*16 +: 16] = rng[31:16];
            end
            planned_before = ops_planned;
            predict_traffic(tag, set_index, is_write);
            mem_read        <= !is_write;
            mem_write       <= is_write;
            mem_byte_enable <= mask;
            mem_wdata       <= data;

            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!mem_resp);

            if (is_write) begin
                shadow[line] = merge_bytes(shadow[line], data, mask);
            end else begin
                assert (mem_rdata == shadow[line])
                    else report_mismatch("mem_rdata", shadow[line], mem_rdata);
            end
            assert (ops_seen == ops_planned)
                else report_problem("request answered before its memory traffic was done");
            if (ops_planned == planned_before) begin
                assert (waited == 1) else report_problem("hit not answered in its first cycle");
            end

            @(posedge clk);
            // now and then an idle cycle between requests
            rng = lcg_next(rng);
            if (rng[18:16] == 3'd0) begin
                mem_read  <= 1'b0;
                mem_write <= 1'b0;
                @(posedge clk);
            end
        end
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        repeat (4) @(posedge clk);

        protocol_errors = uut.protocol_checks.failures;
        $display("errors: %0d value, %0d other, %0d protocol",
                 value_errors, other_errors, protocol_errors);
        if (value_errors + other_errors + protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_cycles * period_ns);
        $display("ERROR cache stopped answering, run ended after %0d cycles", timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : tb_clock

`default_nettype wire
